//--- pixelCore.f
hw/isaPkg.sv
hw/coreCfgPkg.sv
hw/decodeIf.sv
hw/instrIntake.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/pixelCore.sv
bench/pixelCoreTb.sv

//--- bench/pixelCoreTb.sv
module pixelCoreTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst;
    logic                  req;
    isaPkg::instrT         instr;
    logic                  ack;
    logic                  pixelValid;
    coreCfgPkg::pixelAddrT pixelAddr;
    coreCfgPkg::dataT      pixelData;
    coreCfgPkg::colourT    pixelColour;

    logic [31:0] lfsr = 32'h16a6e32f;
    logic [17:0] model [32];   // Expected register contents
    logic [32:0] expQ [$];     // {addr, data, colour} per store
    string       nameQ [$];    // Test that issued each store
    logic [32:0] pixelExp;
    string       pixelTest;
    string       testName = "reset";
    int          errors = 0;
    int          checks = 0;
    int          issued = 0;
    int          cycles = 0;

    pixelCore pixelCore_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .instr      (instr),
        .ack        (ack),
        .pixelValid (pixelValid),
        .pixelAddr  (pixelAddr),
        .pixelData  (pixelData),
        .pixelColour(pixelColour)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsrStep();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'h80200003; // Taps 32, 22, 2, 1
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrStep()};
        end
        return value;
    endfunction

    function automatic isaPkg::instrT aluInstr(input logic [1:0] cls, input logic [1:0] op,
            input logic inm, input logic [4:0] rs1, input logic [4:0] f2,
            input logic [4:0] rd, input logic [12:0] imm);
        if (inm) begin
            return {1'b1, cls, op, rs1, f2, 5'd0, imm};
        end
        return {1'b0, cls, op, rs1, f2, 13'd0, rd};
    endfunction

    function automatic isaPkg::instrT storeInstr(input logic [1:0] colour,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] imm);
        return {1'b1, 2'b10, colour, rs1, rs2, 5'd0, imm};
    endfunction

    function automatic isaPkg::instrT moveInstr(input logic [4:0] rd, input logic [17:0] value);
        return {1'b0, 2'b01, 2'b00, 5'd0, rd, value};
    endfunction

    // Runs one instruction on the model and flags a store in the top bit
    function automatic logic [33:0] refExecute(input isaPkg::instrT ins);
        logic [1:0]  cls;
        logic [1:0]  op;
        logic [4:0]  rd;
        logic [17:0] a;
        logic [17:0] b;
        logic [17:0] immShort;
        logic [17:0] result;
        cls      = ins[31:30];
        op       = ins[29:28];
        immShort = {{5{ins[12]}}, ins[12:0]};
        a        = model[ins[27:23]];
        b        = ins[32] ? immShort : model[ins[22:18]];
        rd       = (ins[32] || (cls == 2'b01 && op == 2'b00)) ? ins[22:18] : ins[4:0];
        result   = '0;
        case (cls)
            2'b00: begin
                case (op)
                    2'b00: result = a + b;
                    2'b01: result = a - b;
                    2'b10: result = a & b;
                    default: result = a | b;
                endcase
            end
            2'b01: begin
                case (op)
                    2'b00: result = ins[17:0];
                    2'b01: result = a << b[3:0];
                    2'b10: result = a >> b[3:0];
                    default: result = {17'd0, $signed(a) < $signed(b)};
                endcase
            end
            2'b10: return {1'b1, 13'(a + immShort), model[ins[22:18]], op};
            default: return '0; // No-op
        endcase
        if (rd != 5'd0) begin
            model[rd] = result;
        end
        return '0;
    endfunction

    task automatic checkValue(input string test, input string field,
            input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    // Four-phase source side entered and left 2 ns after an edge
    task automatic issue(input isaPkg::instrT ins, output int waitCycles);
        logic [33:0] expected;
        expected = refExecute(ins);
        if (expected[33]) begin
            expQ.push_back(expected[32:0]);
            nameQ.push_back(testName);
        end
        issued++;
        instr = ins;
        req = 1'b1;
        waitCycles = 0;
        while (!ack) begin
            @(posedge clk);
            #2;
            waitCycles++;
        end
        req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(negedge clk) begin
        if (rst && pixelValid) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("unexpected pixel write to address %h in %s", pixelAddr, testName);
            end else begin
                pixelExp  = expQ.pop_front();
                pixelTest = nameQ.pop_front();
                checkValue(pixelTest, "pixel addr", pixelExp[32:20], pixelAddr);
                checkValue(pixelTest, "pixel data", pixelExp[19:2], pixelData);
                checkValue(pixelTest, "pixel colour", pixelExp[1:0], pixelColour);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * issued + 100) begin
            $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
            $display("%0d checks, %0d errors", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int          waitCycles;
        logic [1:0]  cls;
        logic [1:0]  op;
        logic        inm;
        logic [4:0]  rs1;
        logic [4:0]  f2;
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [17:0] value;
        rst = 1'b0;
        req = 1'b0;
        instr = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #2;
            checkValue(testName, "idle ack", 0, ack);
            checkValue(testName, "idle pixelValid", 0, pixelValid);
        end
        issue(storeInstr(2'b01, 5'd0, 5'd0, 13'h0123), waitCycles);

        testName = "moveImm";
        for (int r = 1; r <= 6; r++) begin
            value = randBits(18);
            issue(moveInstr(r, value), waitCycles);
            issue(storeInstr(randBits(2), 5'd0, r, randBits(13)), waitCycles);
        end

        testName = "aluRandom";
        repeat (40) begin
            cls = randBits(1);
            op  = randBits(2);
            inm = randBits(1);
            rs1 = randBits(5);
            f2  = randBits(5);
            rd  = randBits(5);
            issue(aluInstr(cls, op, inm, rs1, f2, rd, randBits(13)), waitCycles);
            if (inm || (cls == 2'b01 && op == 2'b00)) begin
                rd = f2;
            end
            issue(storeInstr(randBits(2), 5'd0, rd, randBits(13)), waitCycles);
        end

        testName = "chain";
        repeat (4) begin
            prev = randBits(4) + 1;
            for (int k = 0; k < 6; k++) begin
                cls = randBits(1);
                op  = randBits(2);
                inm = randBits(1);
                rd  = randBits(4) + 1; // Never r0 so the scoreboard tracks it
                // Move-immediate also writes the upper field
                f2  = (inm || (cls == 2'b01 && op == 2'b00)) ? rd : randBits(5);
                issue(aluInstr(cls, op, inm, prev, f2, rd, randBits(13)), waitCycles);
                if (k > 0) begin
                    checkValue(testName, "scoreboard stall", 1, waitCycles > 1);
                end
                prev = rd;
            end
            issue(storeInstr(randBits(2), 5'd0, prev, 13'd0), waitCycles);
        end

        testName = "store";
        issue(moveInstr(5'd7, 18'h3fff0), waitCycles);
        for (int c = 0; c < 4; c++) begin
            issue(storeInstr(c, 5'd7, 5'd7, 13'h0020 + c), waitCycles); // Wraps past 13 bits
        end
        issue(moveInstr(5'd0, 18'h2aaaa), waitCycles);
        issue(storeInstr(2'b10, 5'd7, 5'd0, randBits(13)), waitCycles);
        issue({1'b0, 2'b11, 2'b01, 5'd7, 5'd7, 13'd0, 5'd7}, waitCycles);
        issue(storeInstr(2'b11, 5'd0, 5'd7, 13'h1fff), waitCycles);

        repeat (8) @(posedge clk);
        #2;
        if (expQ.size() != 0) begin
            errors += expQ.size();
            $display("missing pixel write, %0d expected stores never appeared", expQ.size());
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- hw/pixelCore.sv
module pixelCore (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  isaPkg::instrT         instr,
    output logic                  ack,
    output logic                  pixelValid,
    output coreCfgPkg::pixelAddrT pixelAddr,
    output coreCfgPkg::dataT      pixelData,
    output coreCfgPkg::colourT    pixelColour
);

    isaPkg::instrT       instrCaptured;
    logic                instrValid;
    logic                wbEnable;
    coreCfgPkg::regAddrT wbAddr;
    coreCfgPkg::dataT    wbData;

    decodeIf decBus ();

    instrIntake instrIntakeInst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .instr     (instr),
        .ack       (ack),
        .instrOut  (instrCaptured),
        .instrValid(instrValid),
        .wbEnable  (wbEnable),    // Clears scoreboard
        .wbAddr    (wbAddr)
    );

    decodeStage decodeStageInst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instrCaptured),
        .instrValid(instrValid),
        .wbEnable  (wbEnable),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .dec       (decBus.decode)
    );

    executeStage executeStageInst (
        .clk        (clk),
        .rst        (rst),
        .dec        (decBus.execute),
        .wbEnable   (wbEnable),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .pixelValid (pixelValid),
        .pixelAddr  (pixelAddr),
        .pixelData  (pixelData),
        .pixelColour(pixelColour)
    );

endmodule

//--- hw/executeStage.sv
module executeStage (
    input  logic                  clk,
    input  logic                  rst,
    decodeIf.execute              dec,
    output logic                  wbEnable,
    output coreCfgPkg::regAddrT   wbAddr,
    output coreCfgPkg::dataT      wbData,
    output logic                  pixelValid,
    output coreCfgPkg::pixelAddrT pixelAddr,
    output coreCfgPkg::dataT      pixelData,
    output coreCfgPkg::colourT    pixelColour
);

    coreCfgPkg::dataT      operandB;
    coreCfgPkg::dataT      aluResult;
    coreCfgPkg::dataT      addrSum;
    coreCfgPkg::pixelAddrT storeAddr;

    assign operandB  = dec.aluSrcImm ? dec.immValue : dec.rs2Value;
    assign addrSum   = dec.rs1Value + dec.immValue;
    assign storeAddr = addrSum[coreCfgPkg::PixelAddrWidth-1:0]; // Wraps to frame size

    always_comb begin
        aluResult = '0;
        case (dec.aluOp)
            isaPkg::AluAdd:  aluResult = dec.rs1Value + operandB;
            isaPkg::AluSub:  aluResult = dec.rs1Value - operandB;
            isaPkg::AluAnd:  aluResult = dec.rs1Value & operandB;
            isaPkg::AluOr:   aluResult = dec.rs1Value | operandB;
            isaPkg::AluPass: aluResult = operandB;
            isaPkg::AluShl:  aluResult = dec.rs1Value << operandB[3:0];
            isaPkg::AluShr:  aluResult = dec.rs1Value >> operandB[3:0]; // Logical
            isaPkg::AluSlt:  aluResult[0] = $signed(dec.rs1Value) < $signed(operandB);
            default:         aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wbEnable   <= 1'b0;
            pixelValid <= 1'b0;
        end else begin
            wbEnable   <= dec.valid && dec.regWrite;
            pixelValid <= dec.valid && dec.pixelWrite; // Single cycle per store
        end
    end

    always_ff @(posedge clk) begin
        wbAddr      <= dec.rd;
        wbData      <= aluResult;
        pixelAddr   <= storeAddr;
        pixelData   <= dec.rs2Value;
        pixelColour <= dec.colour;
    end

endmodule

//--- hw/decodeStage.sv
module decodeStage (
    input logic                clk,
    input logic                rst,
    input isaPkg::instrT       instr,
    input logic                instrValid,
    input logic                wbEnable,
    input coreCfgPkg::regAddrT wbAddr,
    input coreCfgPkg::dataT    wbData,
    decodeIf.decode            dec
);

    localparam int SignBits = coreCfgPkg::DataWidth - isaPkg::ImmShortHi - 1;

    logic                regWrite;
    logic                aluSrcImm;
    logic                pixelWrite;
    isaPkg::aluOpE       aluOp;
    isaPkg::immSrcE      immSrc;
    coreCfgPkg::regAddrT rs1Addr;
    coreCfgPkg::regAddrT rs2Addr;
    coreCfgPkg::dataT    rs1Value;
    coreCfgPkg::dataT    rs2Value;
    coreCfgPkg::dataT    immExt;

    assign rs1Addr = instr[isaPkg::Rs1Hi -: coreCfgPkg::RegAddrWidth];
    assign rs2Addr = instr[isaPkg::Rs2Hi -: coreCfgPkg::RegAddrWidth];

    controlUnit controlUnitInst (
        .instrClass(isaPkg::instrClassE'(instr[isaPkg::ClassHi -: 2])),
        .op        (instr[isaPkg::OpHi -: 2]),
        .inm       (instr[isaPkg::InmBit]),
        .regWrite  (regWrite),
        .aluSrcImm (aluSrcImm),
        .pixelWrite(pixelWrite),
        .aluOp     (aluOp),
        .immSrc    (immSrc)
    );

    registerFile registerFileInst (
        .clk        (clk),
        .rst        (rst),
        .readAddr1  (rs1Addr),
        .readAddr2  (rs2Addr),
        .writeAddr  (wbAddr),
        .writeEnable(wbEnable),
        .writeData  (wbData),
        .readData1  (rs1Value),
        .readData2  (rs2Value)
    );

    always_comb begin
        if (immSrc == isaPkg::ImmFull18) begin
            immExt = instr[isaPkg::ImmFullHi:0];
        end else begin
            immExt = {{SignBits{instr[isaPkg::ImmShortHi]}}, instr[isaPkg::ImmShortHi:0]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec.valid      <= 1'b0;
            dec.regWrite   <= 1'b0;
            dec.pixelWrite <= 1'b0;
        end else begin
            dec.valid      <= instrValid;
            dec.regWrite   <= regWrite;
            dec.pixelWrite <= pixelWrite;
        end
    end

    always_ff @(posedge clk) begin
        dec.aluOp     <= aluOp;
        dec.aluSrcImm <= aluSrcImm;
        dec.colour    <= coreCfgPkg::colourT'(instr[isaPkg::OpHi -: 2]); // Store colour is op
        dec.rd        <= isaPkg::destField(instr);
        dec.rs1Value  <= rs1Value;
        dec.rs2Value  <= rs2Value;
        dec.immValue  <= immExt;
    end

endmodule

//--- hw/registerFile.sv
module registerFile (
    input  logic                clk,
    input  logic                rst,
    input  coreCfgPkg::regAddrT readAddr1,
    input  coreCfgPkg::regAddrT readAddr2,
    input  coreCfgPkg::regAddrT writeAddr,
    input  logic                writeEnable,
    input  coreCfgPkg::dataT    writeData,
    output coreCfgPkg::dataT    readData1,
    output coreCfgPkg::dataT    readData2
);

    coreCfgPkg::dataT regs [coreCfgPkg::RegCount];

    assign readData1 = regs[readAddr1]; // No write bypass
    assign readData2 = regs[readAddr2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < coreCfgPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData; // r0 stays zero
        end
    end

endmodule

//--- hw/controlUnit.sv
module controlUnit (
    input  isaPkg::instrClassE instrClass,
    input  logic [1:0]         op,
    input  logic               inm,
    output logic               regWrite,
    output logic               aluSrcImm,
    output logic               pixelWrite,
    output isaPkg::aluOpE      aluOp,
    output isaPkg::immSrcE     immSrc
);

    always_comb begin
        regWrite   = 1'b0;
        aluSrcImm  = 1'b0;
        pixelWrite = 1'b0;
        aluOp      = isaPkg::AluAdd;
        immSrc     = isaPkg::ImmShort13;
        case (instrClass)
            isaPkg::ClassAlu: begin
                regWrite  = 1'b1;
                aluSrcImm = inm;
                aluOp     = isaPkg::aluOpE'({1'b0, op}); // add, sub, and, or
            end
            isaPkg::ClassImmShift: begin
                regWrite = 1'b1;
                aluOp    = isaPkg::aluOpE'({1'b1, op}); // pass, shl, shr, slt
                if (op == 2'b00) begin
                    aluSrcImm = 1'b1; // Move-immediate
                    immSrc    = isaPkg::ImmFull18;
                end else begin
                    aluSrcImm = inm;
                end
            end
            isaPkg::ClassPixel: begin
                pixelWrite = 1'b1;
                aluSrcImm  = 1'b1; // Address offset
            end
            default: begin
                // No-op keeps every enable low
                regWrite   = 1'b0;
                pixelWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/instrIntake.sv
module instrIntake (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  isaPkg::instrT       instr,
    output logic                ack,
    output isaPkg::instrT       instrOut,
    output logic                instrValid,
    input  logic                wbEnable,
    input  coreCfgPkg::regAddrT wbAddr
);

    typedef enum logic {
        Idle,
        WaitReqLow
    } stateE;

    stateE                           state;
    logic [coreCfgPkg::RegCount-1:0] pending; // Writes still in flight
    isaPkg::instrClassE              instrClass;
    coreCfgPkg::regAddrT             src1;
    coreCfgPkg::regAddrT             src2;
    coreCfgPkg::regAddrT             dest;
    logic                            writesReg;
    logic                            hazard;
    logic                            capture;

    assign instrClass = isaPkg::instrClassE'(instr[isaPkg::ClassHi -: 2]);
    assign src1       = instr[isaPkg::Rs1Hi -: coreCfgPkg::RegAddrWidth];
    assign src2       = instr[isaPkg::Rs2Hi -: coreCfgPkg::RegAddrWidth];
    assign dest       = isaPkg::destField(instr);
    assign writesReg  = instrClass == isaPkg::ClassAlu || instrClass == isaPkg::ClassImmShift;

    // Conservative: any field that may name a register blocks intake
    assign hazard  = pending[src1] | pending[src2] | pending[dest];
    assign capture = state == Idle && req && !hazard;
    assign ack     = state == WaitReqLow;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= Idle;
            instrValid <= 1'b0;
        end else begin
            instrValid <= capture; // One cycle pulse
            case (state)
                Idle: begin
                    if (capture) begin
                        state <= WaitReqLow;
                    end
                end
                WaitReqLow: begin
                    if (!req) begin
                        state <= Idle; // Drops ack
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= '0;
        end else begin
            if (wbEnable) begin
                pending[wbAddr] <= 1'b0;
            end
            if (capture && writesReg && dest != '0) begin
                pending[dest] <= 1'b1; // r0 never waits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instrOut <= instr;
        end
    end

endmodule

//--- hw/decodeIf.sv
interface decodeIf;

    logic                valid;
    isaPkg::aluOpE       aluOp;
    logic                aluSrcImm;  // Second operand from immediate
    logic                regWrite;
    logic                pixelWrite;
    coreCfgPkg::colourT  colour;
    coreCfgPkg::regAddrT rd;
    coreCfgPkg::dataT    rs1Value;
    coreCfgPkg::dataT    rs2Value;
    coreCfgPkg::dataT    immValue;   // Already extended

    modport decode(
        output valid, aluOp, aluSrcImm, regWrite, pixelWrite,
        output colour, rd, rs1Value, rs2Value, immValue
    );

    modport execute(
        input valid, aluOp, aluSrcImm, regWrite, pixelWrite,
        input colour, rd, rs1Value, rs2Value, immValue
    );

endinterface

//--- hw/coreCfgPkg.sv
package coreCfgPkg;

    localparam int DataWidth      = 18;
    localparam int RegAddrWidth   = 5;
    localparam int RegCount       = 32;
    localparam int PixelAddrWidth = 13;
    localparam int ColourWidth    = 2;

    typedef logic [DataWidth-1:0]      dataT;      // Register value
    typedef logic [RegAddrWidth-1:0]   regAddrT;
    typedef logic [PixelAddrWidth-1:0] pixelAddrT; // Frame address
    typedef logic [ColourWidth-1:0]    colourT;

endpackage

//--- hw/isaPkg.sv
package isaPkg;

    localparam int InstrWidth = 33;

    localparam int InmBit       = 32; // Immediate form flag
    localparam int ClassHi      = 31;
    localparam int OpHi         = 29;
    localparam int Rs1Hi        = 27;
    localparam int Rs2Hi        = 22; // Also rd in immediate form
    localparam int RdRegHi      = 4;  // rd in register form
    localparam int ImmShortHi   = 12;
    localparam int ImmFullHi    = 17;
    localparam int RegFieldWidth = Rs1Hi - Rs2Hi;

    typedef logic [InstrWidth-1:0] instrT;

    typedef enum logic [1:0] {
        ClassAlu      = 2'b00,
        ClassImmShift = 2'b01,
        ClassPixel    = 2'b10,
        ClassNop      = 2'b11
    } instrClassE;

    // Low half follows the op field of classes 00 and 01
    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluPass, AluShl, AluShr, AluSlt
    } aluOpE;

    typedef enum logic {
        ImmShort13,
        ImmFull18
    } immSrcE;

    function automatic logic isMoveImm(instrT instr);
        return instr[ClassHi -: 2] == ClassImmShift && instr[OpHi -: 2] == 2'b00;
    endfunction

    // Destination field for immediate form or move-immediate, else the low field
    function automatic logic [RegFieldWidth-1:0] destField(instrT instr);
        if (instr[InmBit] || isMoveImm(instr)) begin
            return instr[Rs2Hi -: RegFieldWidth];
        end
        return instr[RdRegHi -: RegFieldWidth];
    endfunction

endpackage
